// ==== Makefile ====
TOP = tb_mem_subsystem
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f mem_subsystem.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -qF ">>> FAIL" $(LOG) || ! grep -qF ">>> PASS" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== ahb_master.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module ahb_master import soc_bus_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  mem_req_t         req,
  output mem_rsp_t         rsp,
  output ahb_cmd_t         ahb,
  output logic [2:0]       hburst,
  output logic [2:0]       hsize,
  output logic             hmastlock,
  input  logic [`XLEN-1:0] hrdata,
  input  logic             hready,
  input  logic             hresp
);

  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_nonseq = 2'b10;

  ahb_state_e state;
  ahb_state_e state_n;
  ahb_cmd_t   cmd_d;
  ahb_cmd_t   cmd_q;

  // address phase built straight from the core request
  always_comb begin
    cmd_d.haddr  = req.addr;
    cmd_d.htrans = req.valid ? htrans_nonseq : htrans_idle;
    cmd_d.hwrite = req.valid & (|req.wstrb);
    // hprot bit 0 set means data access, clear means opcode fetch
    cmd_d.hprot  = {3'b000, ~req.instr};
    cmd_d.hwdata = req.wdata;
  end

  always_comb begin
    state_n = state;
    case (state)
      st_idle: begin
        if (req.valid) begin
          state_n = st_active;
        end
      end
      st_active: begin
        if (hready) begin
          state_n = st_idle;
        end
      end
      default: begin
        state_n = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= st_idle;
    end else begin
      state <= state_n;
    end
  end

  // command captured when the address phase is issued
  always_ff @(posedge clk) begin
    if (state == st_idle && req.valid) begin
      cmd_q <= cmd_d;
    end
  end

  always_comb begin
    if (state == st_idle) begin
      ahb        = cmd_d;
      ahb.hwdata = cmd_q.hwdata;
    end else begin
      // data phase only, no second address phase goes out
      ahb        = cmd_q;
      ahb.htrans = htrans_idle;
    end
  end

  assign hburst    = 3'b000;
  assign hsize     = 3'b010;
  assign hmastlock = 1'b0;

  assign rsp.ready = (state == st_active) & hready;
  assign rsp.err   = (state == st_active) & hready & hresp;
  assign rsp.rdata = hrdata;

endmodule

`default_nettype wire

// ==== ahb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module ahb_mem_model import soc_bus_pkg::*; #(
  parameter logic [`XLEN-1:0] err_addr = `AHB_BASE + 32'h3fc
) (
  input  logic             clk,
  input  logic             rst,
  input  ahb_cmd_t         ahb,
  input  logic [1:0]       wait_sel,
  output logic [`XLEN-1:0] hrdata,
  output logic             hready,
  output logic             hresp
);

  logic [`XLEN-1:0] mem [256];
  logic [7:0]       idx_q = 8'd0;
  logic             write_q = 1'b0;
  logic             bad_q = 1'b0;
  logic             busy = 1'b0;
  logic [1:0]       left = 2'd0;

  // fill pattern built from the whole word index
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
    end
  end

  assign hready = !busy || left == 2'd0;
  assign hresp  = busy && bad_q;
  assign hrdata = mem[idx_q];

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy <= 1'b0;
      left <= 2'd0;
    end else begin
      if (busy && left != 2'd0) begin
        left <= left - 2'd1;
      end
      if (busy && left == 2'd0) begin
        busy <= 1'b0;
      end
      // address phase of a nonsequential transfer
      if (hready && ahb.htrans == 2'b10) begin
        busy    <= 1'b1;
        left    <= wait_sel;
        idx_q   <= ahb.haddr[9:2];
        write_q <= ahb.hwrite;
        bad_q   <= ahb.haddr == err_addr;
      end
    end
  end

  always @(posedge clk) begin
    if (busy && left == 2'd0 && write_q && !bad_q) begin
      mem[idx_q] <= ahb.hwdata;
    end
  end

endmodule

`default_nettype wire

// ==== mem_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module mem_router import soc_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  mem_req_t req,
  output mem_rsp_t rsp,
  output mem_req_t tcm_req,
  input  mem_rsp_t tcm_rsp,
  output mem_req_t ahb_req,
  input  mem_rsp_t ahb_rsp
);

  localparam logic [`XLEN-1:0] tcm_bytes = `XLEN'(`TCM_WORDS * (`XLEN / 8));

  mem_target_e cur;
  mem_target_e decode;
  logic        in_tcm;
  logic        in_ahb;
  logic        free;

  // offset compare keeps the check valid for any TCM base
  assign in_tcm = (req.addr - `TCM_BASE) < tcm_bytes;
  assign in_ahb = req.addr >= `AHB_BASE;

  always_comb begin
    if (in_tcm) begin
      decode = tgt_tcm;
    end else if (in_ahb) begin
      decode = tgt_ahb;
    end else begin
      decode = tgt_err;
    end
  end

  assign free = (cur == tgt_none);

  always_comb begin
    tcm_req       = req;
    tcm_req.valid = req.valid && free && (decode == tgt_tcm);
    ahb_req       = req;
    ahb_req.valid = req.valid && free && (decode == tgt_ahb);
  end

  // target is held from acceptance until its reply goes back
  always_ff @(posedge clk) begin
    if (!rst) begin
      cur <= tgt_none;
    end else if (free && req.valid) begin
      cur <= decode;
    end else if (rsp.ready) begin
      cur <= tgt_none;
    end
  end

  always_comb begin
    case (cur)
      tgt_tcm: rsp = tcm_rsp;
      tgt_ahb: rsp = ahb_rsp;
      tgt_err: begin
        rsp.ready = 1'b1;
        rsp.err   = 1'b1;
        rsp.rdata = '0;
      end
      default: rsp = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== mem_subsystem.f ====
+incdir+.
soc_bus_pkg.sv
tcm_ram.sv
ahb_master.sv
mem_router.sv
mem_subsystem.sv
tb_clock_gen.sv
ahb_mem_model.sv
mem_subsystem_assert.sv
tb_mem_subsystem.sv

// ==== mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module mem_subsystem import soc_bus_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  mem_req_t         req,
  output mem_rsp_t         rsp,
  output ahb_cmd_t         ahb,
  output logic [2:0]       hburst,
  output logic [2:0]       hsize,
  output logic             hmastlock,
  input  logic [`XLEN-1:0] hrdata,
  input  logic             hready,
  input  logic             hresp
);

  mem_req_t tcm_req;
  mem_rsp_t tcm_rsp;
  mem_req_t ahb_req;
  mem_rsp_t ahb_rsp;

  mem_router i_router (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .rsp     (rsp),
    .tcm_req (tcm_req),
    .tcm_rsp (tcm_rsp),
    .ahb_req (ahb_req),
    .ahb_rsp (ahb_rsp)
  );

  tcm_ram i_tcm (
    .clk (clk),
    .rst (rst),
    .req (tcm_req),
    .rsp (tcm_rsp)
  );

  ahb_master i_ahb (
    .clk       (clk),
    .rst       (rst),
    .req       (ahb_req),
    .rsp       (ahb_rsp),
    .ahb       (ahb),
    .hburst    (hburst),
    .hsize     (hsize),
    .hmastlock (hmastlock),
    .hrdata    (hrdata),
    .hready    (hready),
    .hresp     (hresp)
  );

endmodule

`default_nettype wire

// ==== mem_subsystem_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_assert import soc_bus_pkg::*; (
  input logic     clk,
  input logic     rst,
  input mem_req_t req,
  input mem_rsp_t rsp,
  input mem_req_t tcm_req,
  input mem_rsp_t ahb_rsp,
  input ahb_cmd_t ahb
);

  int failures = 0;

  a_ready_with_req: assert property (@(posedge clk) disable iff (!rst)
    rsp.ready |-> req.valid)
    else begin
      failures++;
      $error("rsp.ready is high while no request is held");
    end

  // the core holds every field until the reply
  a_req_stable: assert property (@(posedge clk) disable iff (!rst)
    req.valid && !rsp.ready |=> $stable(req))
    else begin
      failures++;
      $error("request changed before rsp.ready");
    end

  a_htrans_idle: assert property (@(posedge clk) disable iff (!rst)
    ahb_rsp.ready |=> req.valid || ahb.htrans == 2'b00)
    else begin
      failures++;
      $error("htrans not idle after the end of an AHB transfer");
    end

  a_tcm_latency: assert property (@(posedge clk) disable iff (!rst)
    tcm_req.valid |=> rsp.ready)
    else begin
      failures++;
      $error("TCM reply did not follow in one cycle");
    end

endmodule

bind mem_subsystem mem_subsystem_assert i_checks (
  .clk     (clk),
  .rst     (rst),
  .req     (req),
  .rsp     (rsp),
  .tcm_req (tcm_req),
  .ahb_rsp (ahb_rsp),
  .ahb     (ahb)
);

`default_nettype wire

// ==== soc_bus_defines.svh ====
`ifndef SOC_BUS_DEFINES_SVH
`define SOC_BUS_DEFINES_SVH

// data and address width of the core port and the AHB bus
`define XLEN 32

// tightly-coupled RAM size in words, 4 KiB with 32-bit words
`define TCM_WORDS 1024

// local TCM region starts here and spans TCM_WORDS words
`define TCM_BASE 32'h0000_0000

// AHB region runs from here to the top of the address space
`define AHB_BASE 32'h8000_0000

`endif

// ==== soc_bus_pkg.sv ====
`default_nettype none

`include "soc_bus_defines.svh"

package soc_bus_pkg;

  // single-word request from the core, held until ready
  typedef struct packed {
    logic               valid;
    logic               instr;
    logic [`XLEN-1:0]   addr;
    logic [`XLEN-1:0]   wdata;
    logic [`XLEN/8-1:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic             ready;
    logic             err;
    logic [`XLEN-1:0] rdata;
  } mem_rsp_t;

  // burst, size and lock are constant inside the bridge
  typedef struct packed {
    logic [`XLEN-1:0] haddr;
    logic [1:0]       htrans;
    logic             hwrite;
    logic [3:0]       hprot;
    logic [`XLEN-1:0] hwdata;
  } ahb_cmd_t;

  typedef enum logic [0:0] {
    st_idle,
    st_active
  } ahb_state_e;

  typedef enum logic [1:0] {
    tgt_none,
    tgt_tcm,
    tgt_ahb,
    tgt_err
  } mem_target_e;

endpackage

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rst = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module tb_mem_subsystem import soc_bus_pkg::*; ();

  localparam logic [31:0] err_addr = `AHB_BASE + 32'h3fc;
  localparam int n_pool = 16;
  localparam int n_rand = 40;
  // requests of all tests together, used to size the watchdog
  localparam int n_req = 2 * n_pool + n_rand + 8 + n_rand + 4 + n_pool + 2 + n_rand;

  logic             clk;
  logic             rst;
  mem_req_t         req;
  mem_rsp_t         rsp;
  ahb_cmd_t         ahb;
  logic [2:0]       hburst;
  logic [2:0]       hsize;
  logic             hmastlock;
  logic [`XLEN-1:0] hrdata;
  logic             hready;
  logic             hresp;
  logic [1:0]       wait_sel = 2'd0;
  logic [31:0]      wait_lcg = 32'd13063;
  logic [31:0]      stim_lcg = 32'd13063;
  logic [31:0]      tcm_sb [`TCM_WORDS];
  logic [31:0]      ahb_sb [256];
  logic [9:0]       tcm_pool [n_pool];
  logic [7:0]       ahb_pool [8];
  int               errors = 0;
  int               checks = 0;
  int               tests = 0;
  int               failed = 0;
  int               mark = 0;
  int               ahb_starts = 0;

  tb_clock_gen i_clk (
    .clk (clk),
    .rst (rst)
  );

  mem_subsystem i_dut (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .rsp       (rsp),
    .ahb       (ahb),
    .hburst    (hburst),
    .hsize     (hsize),
    .hmastlock (hmastlock),
    .hrdata    (hrdata),
    .hready    (hready),
    .hresp     (hresp)
  );

  ahb_mem_model #(.err_addr(err_addr)) i_mem (
    .clk      (clk),
    .rst      (rst),
    .ahb      (ahb),
    .wait_sel (wait_sel),
    .hrdata   (hrdata),
    .hready   (hready),
    .hresp    (hresp)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                        input logic [3:0] strb);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        r[8*b +: 8] = data[8*b +: 8];
      end
    end
    return r;
  endfunction

  task automatic rand32(output logic [31:0] r);
    stim_lcg = lcg_next(stim_lcg);
    r = stim_lcg ^ (stim_lcg >> 16);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    int n;
    n = errors - mark;
    mark = errors;
    tests++;
    if (n != 0) begin
      failed++;
    end
    $display("test %s: %0d errors", name, n);
  endtask

  // one request held until ready, sampled on falling edges
  task automatic issue(input logic [31:0] addr, input logic instr, input logic [31:0] wdata,
                       input logic [3:0] wstrb, output logic [31:0] rdata, output logic err,
                       output int waited);
    @(posedge clk);
    req.valid <= 1'b1;
    req.instr <= instr;
    req.addr  <= addr;
    req.wdata <= wdata;
    req.wstrb <= wstrb;
    waited = 0;
    @(negedge clk);
    while (!rsp.ready && waited < 40) begin
      waited++;
      @(negedge clk);
    end
    if (!rsp.ready) begin
      errors++;
      $display("no reply to the request at address %h within 40 cycles", addr);
    end
    rdata = rsp.rdata;
    err = rsp.err;
    @(posedge clk);
    req.valid <= 1'b0;
  endtask

  task automatic tcm_op(input logic [3:0] slot, input logic [3:0] strb);
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rdata;
    logic        err;
    int          waited;
    addr = `TCM_BASE + {20'b0, tcm_pool[slot], 2'b00};
    rand32(data);
    issue(addr, data[31], data, strb, rdata, err, waited);
    check_eq("rsp.err", {31'b0, err}, 32'd0);
    check_eq("tcm latency", 32'(waited), 32'd1);
    if (strb == 4'h0) begin
      check_eq("rsp.rdata", rdata, tcm_sb[tcm_pool[slot]]);
    end else begin
      tcm_sb[tcm_pool[slot]] = merge(tcm_sb[tcm_pool[slot]], data, strb);
    end
  endtask

  // AHB writes are whole words whatever the strobes
  task automatic ahb_op(input logic [2:0] slot, input logic write);
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rdata;
    logic        err;
    int          waited;
    addr = `AHB_BASE + {22'b0, ahb_pool[slot], 2'b00};
    rand32(data);
    issue(addr, data[31], data, write ? (data[3:0] | 4'h1) : 4'h0, rdata, err, waited);
    check_eq("rsp.err", {31'b0, err}, 32'd0);
    if (write) begin
      ahb_sb[ahb_pool[slot]] = data;
    end else begin
      check_eq("rsp.rdata", rdata, ahb_sb[ahb_pool[slot]]);
    end
  endtask

  always @(posedge clk) begin
    wait_lcg <= lcg_next(wait_lcg);
    wait_sel <= wait_lcg[29:28];
  end

  // every address phase must match the request being held
  // and be a single unlocked word transfer
  always @(negedge clk) begin
    if (rst && ahb.htrans == 2'b10) begin
      ahb_starts++;
      check_eq("ahb.hwrite", {31'b0, ahb.hwrite}, {31'b0, |req.wstrb});
      check_eq("ahb.hprot[0]", {31'b0, ahb.hprot[0]}, {31'b0, ~req.instr});
      check_eq("ahb.haddr", ahb.haddr, req.addr);
      check_eq("hburst", {29'b0, hburst}, 32'd0);
      check_eq("hsize", {29'b0, hsize}, 32'd2);
      check_eq("hmastlock", {31'b0, hmastlock}, 32'd0);
    end
  end

  initial begin
    repeat (n_req * 10 + 200) @(posedge clk);
    $display("watchdog expired after %0d cycles", n_req * 10 + 200);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] rdata;
    logic        err;
    int          waited;
    int          starts;
    int          total;
    req = '0;
    repeat (2) @(negedge clk);
    repeat (8) begin
      check_eq("rsp.ready", {31'b0, rsp.ready}, 32'd0);
      check_eq("ahb.htrans", {30'b0, ahb.htrans}, 32'd0);
      @(negedge clk);
    end
    end_test("reset");

    for (int i = 0; i < n_pool; i++) begin
      rand32(r);
      tcm_pool[i] = r[25:16];
      tcm_op(4'(i), 4'hf);
    end
    repeat (n_rand) begin
      rand32(r);
      tcm_op(r[19:16], r[3:0]);
    end
    for (int i = 0; i < n_pool; i++) begin
      tcm_op(4'(i), 4'h0);
    end
    end_test("tcm access");

    for (int i = 0; i < 8; i++) begin
      rand32(r);
      ahb_pool[i] = {1'b0, r[23:17]};
      ahb_op(3'(i), 1'b1);
    end
    repeat (n_rand) begin
      rand32(r);
      ahb_op(r[18:16], r[29]);
    end
    end_test("ahb access");

    // one alias just above the TCM, one in the middle of the hole
    starts = ahb_starts;
    for (int i = 0; i < 4; i++) begin
      rand32(r);
      if (i % 2 == 0) begin
        addr = `TCM_BASE + 32'(`TCM_WORDS * 4) + {20'b0, tcm_pool[i], 2'b00};
      end else begin
        addr = 32'h4000_0000 + {8'b0, r[23:2], 2'b00};
      end
      issue(addr, 1'b0, r, 4'hf, rdata, err, waited);
      check_eq("rsp.err", {31'b0, err}, 32'd1);
      check_eq("error latency", 32'(waited), 32'd1);
    end
    check_eq("ahb transfers", 32'(ahb_starts - starts), 32'd0);
    for (int i = 0; i < n_pool; i++) begin
      tcm_op(4'(i), 4'h0);
    end
    end_test("unmapped");

    issue(err_addr, 1'b0, 32'h0, 4'h0, rdata, err, waited);
    check_eq("rsp.err", {31'b0, err}, 32'd1);
    issue(err_addr, 1'b1, 32'hdead_beef, 4'hf, rdata, err, waited);
    check_eq("rsp.err", {31'b0, err}, 32'd1);
    end_test("ahb error");

    repeat (n_rand) begin
      rand32(r);
      if (r[31]) begin
        tcm_op(r[19:16], r[30] ? r[3:0] : 4'h0);
      end else begin
        ahb_op(r[18:16], r[30]);
      end
    end
    end_test("mixed traffic");

    total = errors + i_dut.i_checks.failures;
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             tests, failed, checks, errors, i_dut.i_checks.failures);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tcm_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module tcm_ram import soc_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  mem_req_t req,
  output mem_rsp_t rsp
);

  localparam int aw = $clog2(`TCM_WORDS);
  localparam int nbytes = `XLEN / 8;

  logic [`XLEN-1:0] mem [`TCM_WORDS];
  logic [`XLEN-1:0] rdata_q;
  logic             ready_q;
  logic             accept;
  logic [aw-1:0]    idx;

  // the request stays valid during the reply cycle, so it is not taken twice
  assign accept = req.valid && !ready_q;
  assign idx    = req.addr[aw+1:2];

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      for (int b = 0; b < nbytes; b++) begin
        if (req.wstrb[b]) begin
          mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
      rdata_q <= mem[idx];
    end
  end

  assign rsp.ready = ready_q;
  assign rsp.err   = 1'b0;
  assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire
